//--- esp_proto_pkg.sv
`default_nettype none

package esp_proto_pkg;

  // command byte codes sent by the ESP
  typedef enum logic [7:0] {
    get_cookie          = 8'd0,
    set_breakpoint      = 8'd6,
    clear_breakpoint    = 8'd7,
    enable_breakpoints  = 8'd11,
    disable_breakpoints = 8'd12,
    xray_resume         = 8'd13,
    get_version         = 8'd15,
    abus_read           = 8'd18,
    set_led             = 8'd26
  } cmd_t;

  localparam logic [7:0] COOKIE        = 8'haf;  // link sanity byte
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;
  localparam int         PARAM_MAX     = 3;      // widest command is set_breakpoint

  // number of parameter bytes after the command byte
  function automatic logic [1:0] param_count(cmd_t cmd);
    case (cmd)
      set_breakpoint:   return 2'(PARAM_MAX);  // slot, addr lo, addr hi
      clear_breakpoint: return 2'd1;           // slot
      set_led:          return 2'd1;           // rgb bits
      default:          return 2'd0;
    endcase
  endfunction

  // commands that hand a byte back on the next transfer
  function automatic logic has_reply(cmd_t cmd);
    return (cmd == get_cookie) || (cmd == get_version) || (cmd == abus_read);
  endfunction

endpackage

`default_nettype wire

//--- trs_bus_pkg.sv
`default_nettype none

package trs_bus_pkg;

  localparam int ADDR_W   = 16;  // z80 address bus
  localparam int BP_COUNT = 8;   // breakpoint slots

  typedef logic [ADDR_W-1:0] trs_addr_t;

  typedef logic [$clog2(BP_COUNT)-1:0] bp_idx_t;

  // debug stub sequencing
  // run    normal execution, breakpoints armed
  // stop   stub owns the cpu
  // resume waiting for the cpu to come back to the base address
  typedef enum logic [1:0] {
    xray_run    = 2'b00,
    xray_stop   = 2'b01,
    xray_resume = 2'b11
  } xray_state_t;

endpackage

`default_nettype wire

//--- spi_link.sv
`timescale 1ns/10ps
`default_nettype none

module spi_link (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       spi_sck,
  input  logic       spi_cs_n,
  input  logic       spi_mosi,
  input  logic [7:0] tx_byte,
  input  logic       tx_load,
  output logic       spi_miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  logic [2:0] sck_q;       // sck sync chain
  logic [2:0] cs_q;        // cs sync chain
  logic [1:0] mosi_q;      // mosi sync chain
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;     // bits taken in the current byte
  logic [7:0] sr_in;       // mosi shifter
  logic [7:0] sr_out;      // miso shifter
  logic [7:0] reply_buf;   // byte waiting for the next transfer
  logic       reply_pend;
  logic [3:0] reply_left;  // reply bits not yet clocked out
  logic       load_reply;

  assign sck_rise  = sck_q[1] & ~sck_q[2];
  assign sck_fall  = ~sck_q[1] & sck_q[2];
  assign cs_active = ~cs_q[2];
  // falling edge right after a full byte
  assign load_reply = cs_active && sck_fall && (bit_cnt == 3'd0) && reply_pend;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_q  <= '0;  // mode 0 idles low
      cs_q   <= '1;  // deselected
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], spi_sck};
      cs_q   <= {cs_q[1:0], spi_cs_n};
      mosi_q <= {mosi_q[0], spi_mosi};
    end
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt    <= '0;
      rx_valid   <= 1'b0;
      reply_pend <= 1'b0;
      reply_left <= '0;
    end else begin
      // no byte reported while a reply is going out
      rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7) && (reply_left == 4'd0);
      if (!cs_active) begin
        bit_cnt <= '0;  // cs high restarts byte framing
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
      end
      if (tx_load) begin
        reply_pend <= 1'b1;
      end else if (load_reply) begin
        reply_pend <= 1'b0;
      end
      if (load_reply) begin
        reply_left <= 4'd8;
      end else if (cs_active && sck_rise && (reply_left != 4'd0)) begin
        reply_left <= reply_left - 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      sr_in <= {sr_in[6:0], mosi_q[1]};  // msb first
    end
    if (tx_load) begin
      reply_buf <= tx_byte;
    end
    if (load_reply) begin
      sr_out <= reply_buf;
    end else if (cs_active && sck_fall) begin
      sr_out <= {sr_out[6:0], 1'b0};
    end
  end

  assign rx_byte  = sr_in;  // complete when rx_valid is high
  assign spi_miso = cs_active ? sr_out[7] : 1'bz;

  // a byte only completes inside a framed session
  a_rx_in_session: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    rx_valid |-> cs_active);

endmodule

`default_nettype wire

//--- esp_cmd_parser.sv
`timescale 1ns/10ps
`default_nettype none

module esp_cmd_parser (
  input  logic                   clk,
  input  logic                   cass_out_sel_n,
  input  logic [7:0]             rx_byte,
  input  logic                   rx_valid,
  input  trs_bus_pkg::trs_addr_t trs_addr,
  output logic [7:0]             tx_byte,
  output logic                   tx_load,
  output logic                   action_valid,
  output esp_proto_pkg::cmd_t    action_cmd,
  output logic [7:0]             action_p0,
  output logic [7:0]             action_p1,
  output logic [7:0]             action_p2,
  output logic                   led_red,
  output logic                   led_green,
  output logic                   led_blue,
  output logic                   spi_error
);

  typedef enum logic {
    idle,
    read_params
  } parse_state_t;

  parse_state_t        state;
  esp_proto_pkg::cmd_t cmd_in;    // incoming byte taken as a command
  esp_proto_pkg::cmd_t cmd_reg;   // command still collecting parameters
  logic                cmd_known;
  logic [1:0]          params_left;
  logic [1:0]          p_idx;      // next parameter slot
  logic [7:0]          param_buf [esp_proto_pkg::PARAM_MAX];
  logic [7:0]          p_next [esp_proto_pkg::PARAM_MAX];
  logic [7:0]          reply_byte;
  logic                fire_now;   // zero-parameter command done
  logic                fire_last;  // last parameter byte in

  assign cmd_in = esp_proto_pkg::cmd_t'(rx_byte);

  always_comb begin
    case (cmd_in)
      esp_proto_pkg::get_cookie,
      esp_proto_pkg::set_breakpoint,
      esp_proto_pkg::clear_breakpoint,
      esp_proto_pkg::enable_breakpoints,
      esp_proto_pkg::disable_breakpoints,
      esp_proto_pkg::xray_resume,
      esp_proto_pkg::get_version,
      esp_proto_pkg::abus_read,
      esp_proto_pkg::set_led: cmd_known = 1'b1;
      default:                cmd_known = 1'b0;
    endcase
  end

  always_comb begin
    case (cmd_in)
      esp_proto_pkg::get_cookie:  reply_byte = esp_proto_pkg::COOKIE;
      esp_proto_pkg::get_version: reply_byte = {esp_proto_pkg::VERSION_MAJOR,
                                                esp_proto_pkg::VERSION_MINOR};
      default:                    reply_byte = trs_addr[7:0];  // abus_read
    endcase
  end

  // buffered params with the arriving byte dropped into its slot
  always_comb begin
    for (int i = 0; i < esp_proto_pkg::PARAM_MAX; i++) begin
      p_next[i] = param_buf[i];
    end
    p_next[p_idx] = rx_byte;
  end

  assign fire_now  = rx_valid && (state == idle) && cmd_known &&
                     (esp_proto_pkg::param_count(cmd_in) == 2'd0);
  assign fire_last = rx_valid && (state == read_params) && (params_left == 2'd1);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state        <= idle;
      params_left  <= '0;
      p_idx        <= '0;
      action_valid <= 1'b0;
      tx_load      <= 1'b0;
      spi_error    <= 1'b0;
    end else begin
      action_valid <= fire_now || fire_last;
      tx_load      <= fire_now && esp_proto_pkg::has_reply(cmd_in);
      if (rx_valid) begin
        case (state)
          idle: begin
            if (!cmd_known) begin
              spi_error <= 1'b1;  // sticky until reset
            end else if (!fire_now) begin
              state       <= read_params;
              params_left <= esp_proto_pkg::param_count(cmd_in);
              p_idx       <= '0;
            end
          end
          read_params: begin
            p_idx       <= p_idx + 2'd1;
            params_left <= params_left - 2'd1;
            if (fire_last) begin
              state <= idle;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && (state == idle)) begin
      cmd_reg <= cmd_in;
    end
    if (rx_valid && (state == read_params)) begin
      param_buf[p_idx] <= rx_byte;
    end
    if (fire_now) begin
      action_cmd <= cmd_in;      // params keep their last values
      tx_byte    <= reply_byte;  // only shifted out when tx_load fires
    end else if (fire_last) begin
      action_cmd <= cmd_reg;
      action_p0  <= p_next[0];
      action_p1  <= p_next[1];
      action_p2  <= p_next[2];
    end
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_red   <= 1'b0;
      led_green <= 1'b0;
      led_blue  <= 1'b0;
    end else if (action_valid && (action_cmd == esp_proto_pkg::set_led)) begin
      led_red   <= action_p0[0];
      led_green <= action_p0[1];
      led_blue  <= action_p0[2];
    end
  end

  // one action per received byte at most
  a_action_single: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    action_valid |=> !action_valid);

endmodule

`default_nettype wire

//--- bus_strobe_filter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_strobe_filter (
  input  logic clk,
  input  logic cass_out_sel_n,
  input  logic strobe_n,
  output logic strobe_fall
);

  logic [2:0] strobe_q;  // two sync stages plus one for edge compare

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      strobe_q    <= '1;  // strobe idles high
      strobe_fall <= 1'b0;
    end else begin
      strobe_q    <= {strobe_q[1:0], strobe_n};
      strobe_fall <= strobe_q[2] & ~strobe_q[1];  // high to low seen
    end
  end

endmodule

`default_nettype wire

//--- bp_slot.sv
`timescale 1ns/10ps
`default_nettype none

module bp_slot #(
  parameter int SLOT_INDEX = 0
) (
  input  logic                   clk,
  input  logic                   cass_out_sel_n,
  input  logic                   action_valid,
  input  esp_proto_pkg::cmd_t    action_cmd,
  input  logic [7:0]             action_p0,
  input  logic [7:0]             action_p1,
  input  logic [7:0]             action_p2,
  input  trs_bus_pkg::trs_addr_t trs_addr,
  output logic                   slot_match
);

  trs_bus_pkg::trs_addr_t bp_addr;  // watched address
  logic                   active;
  logic                   for_me;   // p0 names this slot

  assign for_me = action_valid && (action_p0 == 8'(SLOT_INDEX));

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      active <= 1'b0;
    end else if (for_me && (action_cmd == esp_proto_pkg::set_breakpoint)) begin
      active <= 1'b1;
    end else if (for_me && (action_cmd == esp_proto_pkg::clear_breakpoint)) begin
      active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (for_me && (action_cmd == esp_proto_pkg::set_breakpoint)) begin
      bp_addr <= {action_p2, action_p1};  // hi byte, lo byte
    end
  end

  assign slot_match = active && (bp_addr == trs_addr);

endmodule

`default_nettype wire

//--- xray_break_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module xray_break_ctrl #(
  parameter int N_SLOTS = 8
) (
  input  logic                   clk,
  input  logic                   cass_out_sel_n,
  input  logic [N_SLOTS-1:0]     slot_match,
  input  logic                   rd_fall,
  input  trs_bus_pkg::trs_addr_t trs_addr,
  input  logic                   action_valid,
  input  esp_proto_pkg::cmd_t    action_cmd,
  output logic                   xray_stopped,
  output trs_bus_pkg::bp_idx_t   bp_index
);

  trs_bus_pkg::xray_state_t state;
  trs_bus_pkg::trs_addr_t   base_addr;  // where the break hit
  trs_bus_pkg::bp_idx_t     hit_idx;
  logic                     bp_enabled;
  logic                     hit;

  // lowest matching slot wins
  always_comb begin
    hit_idx = '0;
    for (int i = N_SLOTS - 1; i >= 0; i--) begin
      if (slot_match[i]) begin
        hit_idx = trs_bus_pkg::bp_idx_t'(i);
      end
    end
  end

  assign hit = rd_fall && bp_enabled && (|slot_match);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bp_enabled <= 1'b0;
      state      <= trs_bus_pkg::xray_run;
      bp_index   <= '0;
    end else begin
      if (action_valid && (action_cmd == esp_proto_pkg::enable_breakpoints)) begin
        bp_enabled <= 1'b1;
      end else if (action_valid && (action_cmd == esp_proto_pkg::disable_breakpoints)) begin
        bp_enabled <= 1'b0;
      end
      case (state)
        trs_bus_pkg::xray_run: begin
          if (hit) begin
            state    <= trs_bus_pkg::xray_stop;
            bp_index <= hit_idx;
          end
        end
        trs_bus_pkg::xray_stop: begin
          if (action_valid && (action_cmd == esp_proto_pkg::xray_resume)) begin
            state <= trs_bus_pkg::xray_resume;  // stub is leaving
          end
        end
        trs_bus_pkg::xray_resume: begin
          if (rd_fall && (trs_addr == base_addr)) begin
            state <= trs_bus_pkg::xray_run;  // back at the break address
          end
        end
        default: state <= trs_bus_pkg::xray_run;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == trs_bus_pkg::xray_run) && hit) begin
      base_addr <= trs_addr;
    end
  end

  assign xray_stopped = (state != trs_bus_pkg::xray_run);

  // esp reads the index during the whole stop
  a_idx_hold: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    (xray_stopped && $past(xray_stopped)) |-> $stable(bp_index));

endmodule

`default_nettype wire

//--- trs_debug_top.sv
`timescale 1ns/10ps
`default_nettype none

module trs_debug_top (
  input  logic                   clk,
  input  logic                   cass_out_sel_n,
  input  logic                   spi_sck,
  input  logic                   spi_cs_n,
  input  logic                   spi_mosi,
  output logic                   spi_miso,
  input  trs_bus_pkg::trs_addr_t trs_addr,
  input  logic                   trs_rd_n,
  output logic                   led_red,
  output logic                   led_green,
  output logic                   led_blue,
  output logic                   spi_error,
  output logic                   xray_stopped,
  output trs_bus_pkg::bp_idx_t   bp_index
);

  localparam int N_SLOTS = trs_bus_pkg::BP_COUNT;

  logic [7:0]          rx_byte;
  logic                rx_valid;
  logic [7:0]          tx_byte;
  logic                tx_load;
  logic                action_valid;
  esp_proto_pkg::cmd_t action_cmd;
  logic [7:0]          action_p0;
  logic [7:0]          action_p1;
  logic [7:0]          action_p2;
  logic                rd_fall;
  logic [N_SLOTS-1:0]  slot_match;  // one bit per slot

  spi_link spi_link_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_sck        (spi_sck),
    .spi_cs_n       (spi_cs_n),
    .spi_mosi       (spi_mosi),
    .tx_byte        (tx_byte),
    .tx_load        (tx_load),
    .spi_miso       (spi_miso),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid)
  );

  esp_cmd_parser esp_cmd_parser_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .trs_addr       (trs_addr),
    .tx_byte        (tx_byte),
    .tx_load        (tx_load),
    .action_valid   (action_valid),
    .action_cmd     (action_cmd),
    .action_p0      (action_p0),
    .action_p1      (action_p1),
    .action_p2      (action_p2),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .spi_error      (spi_error)
  );

  bus_strobe_filter rd_filter_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .strobe_n       (trs_rd_n),
    .strobe_fall    (rd_fall)
  );

  for (genvar g = 0; g < N_SLOTS; g++) begin : g_slot
    bp_slot #(
      .SLOT_INDEX (g)
    ) bp_slot_i (
      .clk            (clk),
      .cass_out_sel_n (cass_out_sel_n),
      .action_valid   (action_valid),
      .action_cmd     (action_cmd),
      .action_p0      (action_p0),
      .action_p1      (action_p1),
      .action_p2      (action_p2),
      .trs_addr       (trs_addr),
      .slot_match     (slot_match[g])
    );
  end

  xray_break_ctrl #(
    .N_SLOTS (N_SLOTS)
  ) xray_break_ctrl_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .slot_match     (slot_match),
    .rd_fall        (rd_fall),
    .trs_addr       (trs_addr),
    .action_valid   (action_valid),
    .action_cmd     (action_cmd),
    .xray_stopped   (xray_stopped),
    .bp_index       (bp_index)
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // free running
  end

  // reset low from time zero, released just after an edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_trs_debug.sv
`timescale 1ns/10ps
`default_nettype none

module tb_trs_debug;

  localparam int HALF    = 8;    // sck half period in clk cycles
  localparam int TIMEOUT = 200;  // cycles per wait loop
  localparam int RD_LOW  = 6;    // z80 read strobe width
  localparam int N_ROWS  = 31;

  // command codes of the esp link
  localparam logic [7:0] OP_COOKIE = 8'd0;
  localparam logic [7:0] OP_SET_BP = 8'd6;
  localparam logic [7:0] OP_CLR_BP = 8'd7;
  localparam logic [7:0] OP_ENA    = 8'd11;
  localparam logic [7:0] OP_DIS    = 8'd12;
  localparam logic [7:0] OP_RESUME = 8'd13;
  localparam logic [7:0] OP_VERS   = 8'd15;
  localparam logic [7:0] OP_ABUS   = 8'd18;
  localparam logic [7:0] OP_LED    = 8'd26;
  localparam logic [7:0] OP_BAD    = 8'd40;  // not a command

  // address selector 0 is addr_c, 1 is addr_a, 2 is addr_b
  typedef struct packed {
    logic                 send;  // spi command in this row
    logic [7:0]           cmd;
    logic [1:0]           np;    // parameter bytes
    logic [7:0]           p0;
    logic [1:0]           psel;  // address carried in p1/p2
    logic [1:0]           bus;   // address held on trs_addr
    logic                 rd;    // z80 read strobe after the command
    logic [1:0]           rchk;  // 0 no reply, 1 rexp, 2 low byte of bus
    logic [7:0]           rexp;
    logic [2:0]           led;   // blue green red
    logic                 stop;
    trs_bus_pkg::bp_idx_t idx;
    logic                 err;
  } row_t;

  logic                   clk;
  logic                   cass_out_sel_n;
  logic                   spi_sck;
  logic                   spi_cs_n;
  logic                   spi_mosi;
  logic                   spi_miso;
  trs_bus_pkg::trs_addr_t trs_addr;
  logic                   trs_rd_n;
  logic                   led_red;
  logic                   led_green;
  logic                   led_blue;
  logic                   spi_error;
  logic                   xray_stopped;
  trs_bus_pkg::bp_idx_t   bp_index;

  row_t                   rows [N_ROWS];
  trs_bus_pkg::trs_addr_t addr_a;  // slot 2
  trs_bus_pkg::trs_addr_t addr_b;  // slot 5, later slots 1 and 6
  trs_bus_pkg::trs_addr_t addr_c;  // never watched
  integer                 seed = 32'hb056;
  int                     checks = 0;
  int                     errors = 0;
  int                     fails = 0;  // timeouts

  tb_clk_gen #(.PERIOD_NS (10), .RST_CYCLES (4)) clk_gen_i (
    .clk   (clk),
    .rst_n (cass_out_sel_n)
  );

  trs_debug_top trs_debug_top_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_sck        (spi_sck),
    .spi_cs_n       (spi_cs_n),
    .spi_mosi       (spi_mosi),
    .spi_miso       (spi_miso),
    .trs_addr       (trs_addr),
    .trs_rd_n       (trs_rd_n),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .spi_error      (spi_error),
    .xray_stopped   (xray_stopped),
    .bp_index       (bp_index)
  );

  // lands 1 ns after a rising edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_idx(input string name, input trs_bus_pkg::bp_idx_t got,
                           input trs_bus_pkg::bp_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic trs_bus_pkg::trs_addr_t pick_addr(input logic [1:0] sel);
    case (sel)
      2'd1:    return addr_a;
      2'd2:    return addr_b;
      default: return addr_c;
    endcase
  endfunction

  // mode 0 msb first, miso read just before each rising sck
  task automatic spi_xfer(input logic [7:0] mosi_byte, output logic [7:0] miso_byte);
    for (int b = 7; b >= 0; b--) begin
      spi_mosi = mosi_byte[b];
      wait_clks(HALF);
      miso_byte[b] = spi_miso;
      spi_sck = 1'b1;
      wait_clks(HALF);
      spi_sck = 1'b0;
    end
  endtask

  // one cs session with command, params and the reply transfer if any
  task automatic run_command(input row_t row, output logic [7:0] reply);
    trs_bus_pkg::trs_addr_t pa;
    logic [7:0]             unused_rx;
    pa       = pick_addr(row.psel);
    reply    = 8'h00;
    spi_cs_n = 1'b0;
    wait_clks(HALF);
    spi_xfer(row.cmd, unused_rx);
    if (row.np > 2'd0) spi_xfer(row.p0, unused_rx);
    if (row.np > 2'd1) spi_xfer(pa[7:0], unused_rx);   // addr lo
    if (row.np > 2'd2) spi_xfer(pa[15:8], unused_rx);  // addr hi
    if (row.rchk != 2'd0) spi_xfer(OP_BAD, reply);     // never seen by the parser
    wait_clks(HALF);
    spi_cs_n = 1'b1;
    wait_clks(HALF);
  endtask

  task automatic bus_read();
    trs_rd_n = 1'b0;
    wait_clks(RD_LOW);
    trs_rd_n = 1'b1;
    wait_clks(2);
  endtask

  task automatic wait_stopped(input logic exp);
    int n;
    n = 0;
    while ((xray_stopped !== exp) && (n < TIMEOUT)) begin
      wait_clks(1);
      n++;
    end
    if (xray_stopped !== exp) begin
      fails++;
      $display("timeout, xray_stopped never reached %0b after a bus read", exp);
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while ((cass_out_sel_n !== 1'b1) && (n < TIMEOUT)) begin
      wait_clks(1);
      n++;
    end
    if (cass_out_sel_n !== 1'b1) begin
      fails++;
      $display("timeout, reset was never released");
    end
  endtask

  // send cmd np p0 psel bus rd rchk rexp led stop idx err
  task automatic fill_table();
    // replies and leds
    rows[0]  = '{1'b1, OP_COOKIE, 2'd0, 8'h00, 2'd0, 2'd0, 1'b0, 2'd1, 8'haf, 3'b000, 1'b0, 3'd0, 1'b0};
    rows[1]  = '{1'b1, OP_VERS, 2'd0, 8'h00, 2'd0, 2'd0, 1'b0, 2'd1, 8'h03, 3'b000, 1'b0, 3'd0, 1'b0};
    rows[2]  = '{1'b1, OP_ABUS, 2'd0, 8'h00, 2'd0, 2'd1, 1'b0, 2'd2, 8'h00, 3'b000, 1'b0, 3'd0, 1'b0};
    rows[3]  = '{1'b1, OP_ABUS, 2'd0, 8'h00, 2'd0, 2'd2, 1'b0, 2'd2, 8'h00, 3'b000, 1'b0, 3'd0, 1'b0};
    rows[4]  = '{1'b1, OP_LED, 2'd1, 8'h05, 2'd0, 2'd0, 1'b0, 2'd0, 8'h00, 3'b101, 1'b0, 3'd0, 1'b0};
    rows[5]  = '{1'b1, OP_LED, 2'd1, 8'hfa, 2'd0, 2'd0, 1'b0, 2'd0, 8'h00, 3'b010, 1'b0, 3'd0, 1'b0};
    rows[6]  = '{1'b1, OP_BAD, 2'd0, 8'h00, 2'd0, 2'd0, 1'b0, 2'd0, 8'h00, 3'b010, 1'b0, 3'd0, 1'b1};
    rows[7]  = '{1'b1, OP_COOKIE, 2'd0, 8'h00, 2'd0, 2'd0, 1'b0, 2'd1, 8'haf, 3'b010, 1'b0, 3'd0, 1'b1};
    // slots 2 and 5, hits only once enabled
    rows[8]  = '{1'b1, OP_SET_BP, 2'd3, 8'h02, 2'd1, 2'd0, 1'b0, 2'd0, 8'h00, 3'b010, 1'b0, 3'd0, 1'b1};
    rows[9]  = '{1'b1, OP_SET_BP, 2'd3, 8'h05, 2'd2, 2'd0, 1'b0, 2'd0, 8'h00, 3'b010, 1'b0, 3'd0, 1'b1};
    rows[10] = '{1'b0, 8'h00, 2'd0, 8'h00, 2'd0, 2'd2, 1'b1, 2'd0, 8'h00, 3'b010, 1'b0, 3'd0, 1'b1};
    rows[11] = '{1'b1, OP_ENA, 2'd0, 8'h00, 2'd0, 2'd0, 1'b0, 2'd0, 8'h00, 3'b010, 1'b0, 3'd0, 1'b1};
    rows[12] = '{1'b0, 8'h00, 2'd0, 8'h00, 2'd0, 2'd0, 1'b1, 2'd0, 8'h00, 3'b010, 1'b0, 3'd0, 1'b1};
    rows[13] = '{1'b0, 8'h00, 2'd0, 8'h00, 2'd0, 2'd2, 1'b1, 2'd0, 8'h00, 3'b010, 1'b1, 3'd5, 1'b1};
    // resume leaves stop only at the base address
    rows[14] = '{1'b1, OP_RESUME, 2'd0, 8'h00, 2'd0, 2'd0, 1'b0, 2'd0, 8'h00, 3'b010, 1'b1, 3'd5, 1'b1};
    rows[15] = '{1'b0, 8'h00, 2'd0, 8'h00, 2'd0, 2'd1, 1'b1, 2'd0, 8'h00, 3'b010, 1'b1, 3'd5, 1'b1};
    rows[16] = '{1'b0, 8'h00, 2'd0, 8'h00, 2'd0, 2'd2, 1'b1, 2'd0, 8'h00, 3'b010, 1'b0, 3'd5, 1'b1};
    // cleared slot 5 is silent, slot 2 still hits
    rows[17] = '{1'b1, OP_CLR_BP, 2'd1, 8'h05, 2'd0, 2'd0, 1'b0, 2'd0, 8'h00, 3'b010, 1'b0, 3'd5, 1'b1};
    rows[18] = '{1'b0, 8'h00, 2'd0, 8'h00, 2'd0, 2'd2, 1'b1, 2'd0, 8'h00, 3'b010, 1'b0, 3'd5, 1'b1};
    rows[19] = '{1'b0, 8'h00, 2'd0, 8'h00, 2'd0, 2'd1, 1'b1, 2'd0, 8'h00, 3'b010, 1'b1, 3'd2, 1'b1};
    rows[20] = '{1'b1, OP_RESUME, 2'd0, 8'h00, 2'd0, 2'd0, 1'b0, 2'd0, 8'h00, 3'b010, 1'b1, 3'd2, 1'b1};
    rows[21] = '{1'b0, 8'h00, 2'd0, 8'h00, 2'd0, 2'd1, 1'b1, 2'd0, 8'h00, 3'b010, 1'b0, 3'd2, 1'b1};
    // slots 6 and 1 share one address and the lower index wins
    rows[22] = '{1'b1, OP_SET_BP, 2'd3, 8'h06, 2'd2, 2'd0, 1'b0, 2'd0, 8'h00, 3'b010, 1'b0, 3'd2, 1'b1};
    rows[23] = '{1'b1, OP_SET_BP, 2'd3, 8'h01, 2'd2, 2'd0, 1'b0, 2'd0, 8'h00, 3'b010, 1'b0, 3'd2, 1'b1};
    rows[24] = '{1'b0, 8'h00, 2'd0, 8'h00, 2'd0, 2'd2, 1'b1, 2'd0, 8'h00, 3'b010, 1'b1, 3'd1, 1'b1};
    rows[25] = '{1'b1, OP_RESUME, 2'd0, 8'h00, 2'd0, 2'd0, 1'b0, 2'd0, 8'h00, 3'b010, 1'b1, 3'd1, 1'b1};
    rows[26] = '{1'b0, 8'h00, 2'd0, 8'h00, 2'd0, 2'd2, 1'b1, 2'd0, 8'h00, 3'b010, 1'b0, 3'd1, 1'b1};
    // armed slots ignored while globally disabled
    rows[27] = '{1'b1, OP_DIS, 2'd0, 8'h00, 2'd0, 2'd0, 1'b0, 2'd0, 8'h00, 3'b010, 1'b0, 3'd1, 1'b1};
    rows[28] = '{1'b0, 8'h00, 2'd0, 8'h00, 2'd0, 2'd2, 1'b1, 2'd0, 8'h00, 3'b010, 1'b0, 3'd1, 1'b1};
    rows[29] = '{1'b0, 8'h00, 2'd0, 8'h00, 2'd0, 2'd1, 1'b1, 2'd0, 8'h00, 3'b010, 1'b0, 3'd1, 1'b1};
    rows[30] = '{1'b1, OP_VERS, 2'd0, 8'h00, 2'd0, 2'd0, 1'b0, 2'd1, 8'h03, 3'b010, 1'b0, 3'd1, 1'b1};
  endtask

  task automatic apply_row(input row_t row);
    logic [7:0] reply;
    reply    = 8'h00;
    trs_addr = pick_addr(row.bus);  // held through the whole row
    if (row.send) run_command(row, reply);
    if (row.rd) begin
      bus_read();
      wait_stopped(row.stop);
    end
    if (row.rchk == 2'd1) check_byte("spi_miso reply", reply, row.rexp);
    if (row.rchk == 2'd2) check_byte("spi_miso abus", reply, trs_addr[7:0]);
    check_bit("led_red", led_red, row.led[0]);
    check_bit("led_green", led_green, row.led[1]);
    check_bit("led_blue", led_blue, row.led[2]);
    check_bit("spi_error", spi_error, row.err);
    check_bit("xray_stopped", xray_stopped, row.stop);
    check_idx("bp_index", bp_index, row.idx);
  endtask

  initial begin
    spi_sck  = 1'b0;
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    trs_addr = '0;
    trs_rd_n = 1'b1;
    addr_a   = 16'($random(seed));
    addr_b   = 16'($random(seed));
    if (addr_b == addr_a) addr_b = ~addr_a;
    addr_c = addr_a + 16'd1;
    if (addr_c == addr_b) addr_c = addr_a + 16'd2;
    fill_table();
    wait_reset_release();
    wait_clks(2);
    // outputs straight out of reset
    check_bit("led_red", led_red, 1'b0);
    check_bit("led_green", led_green, 1'b0);
    check_bit("led_blue", led_blue, 1'b0);
    check_bit("spi_error", spi_error, 1'b0);
    check_bit("xray_stopped", xray_stopped, 1'b0);
    check_idx("bp_index", bp_index, 3'd0);
    for (int r = 0; r < N_ROWS; r++) begin
      apply_row(rows[r]);
    end
    $display("checks %0d, value errors %0d, other failures %0d", checks, errors, fails);
    if ((errors == 0) && (fails == 0)) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
esp_proto_pkg.sv
trs_bus_pkg.sv
spi_link.sv
esp_cmd_parser.sv
bus_strobe_filter.sv
bp_slot.sv
xray_break_ctrl.sv
trs_debug_top.sv
tb_clk_gen.sv
tb_trs_debug.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_trs_debug
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
